/* rtl/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// word address width seen by the front end and the back end
`define CACHE_ADDR_W 12

// data word width, one word per line
`define CACHE_DATA_W 32

// number of ways, 2 or 4
`define CACHE_NWAYS 2

// set index bits taken from the low end of the address
`define CACHE_INDEX_W 3

`endif

/* rtl/cache_geom_pkg.sv */
`include "cache_settings.svh"

package cache_geom_pkg;

   // one data word
   typedef logic [`CACHE_DATA_W-1:0] word_t;

   // low address bits pick the set
   typedef logic [`CACHE_INDEX_W-1:0] index_t;

   // the rest of the address is stored as the tag
   typedef logic [`CACHE_ADDR_W-`CACHE_INDEX_W-1:0] tag_t;

   // at least one bit, even for a single way
   typedef logic [(`CACHE_NWAYS > 1 ? $clog2(`CACHE_NWAYS) : 1)-1:0] way_t;

   typedef struct packed {
      logic   we;
      tag_t   tag;
      index_t index;
      word_t  wdata;
   } cache_req_t;

endpackage

/* rtl/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

   // lookup is the cycle in which the ways answer
   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_refill,
      st_write_through,
      st_flush
   } ctrl_state_e;

   // encoding matches mem_we_o
   typedef enum logic {
      mem_read  = 1'b0,
      mem_write = 1'b1
   } mem_op_e;

endpackage

/* rtl/cache_way_if.sv */
`timescale 1ns/1ns

interface cache_way_if;
   import cache_geom_pkg::*;

   // lookup broadcast from the front end
   logic   lookup_en;
   index_t lookup_index;
   tag_t   lookup_tag;

   // answer of the way
   logic   hit;
   word_t  rdata;

   // writes requested by the controller
   logic   fill_en;
   logic   update_en;
   logic   flush_en;
   word_t  wr_data;

   modport front_end (output lookup_en, lookup_index, lookup_tag);

   modport way (input lookup_en, lookup_index, lookup_tag,
                input fill_en, update_en, flush_en, wr_data,
                output hit, rdata);

   modport ctrl (output fill_en, update_en, flush_en, wr_data,
                 input hit, rdata);

endinterface

/* rtl/cache_front_end.sv */
`timescale 1ns/1ns

`include "cache_settings.svh"

module cache_front_end (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       req_i,
   input  logic [`CACHE_ADDR_W-1:0]   addr_i,
   input  logic                       we_i,
   input  cache_geom_pkg::word_t      wdata_i,
   input  logic                       ready_i,
   output cache_geom_pkg::cache_req_t req_o,
   output logic                       req_valid_o,
   cache_way_if.front_end             ways [`CACHE_NWAYS]
);
   import cache_geom_pkg::*;

   logic   accept;
   tag_t   addr_tag;
   index_t addr_index;

   assign accept     = req_i && ready_i;
   assign addr_index = addr_i[`CACHE_INDEX_W-1:0];
   assign addr_tag   = addr_i[`CACHE_ADDR_W-1:`CACHE_INDEX_W];

   // every way starts its synchronous read on the accept edge
   for (genvar i = 0; i < `CACHE_NWAYS; i++) begin : g_lookup
      assign ways[i].lookup_en    = accept;
      assign ways[i].lookup_index = addr_index;
      assign ways[i].lookup_tag   = addr_tag;
   end

   // one-cycle strobe, the controller sees it while the ways answer
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         req_valid_o <= 1'b0;
      end else begin
         req_valid_o <= accept;
      end
   end

   // held until the next accept, the controller reads it through the miss
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_o.we    <= we_i;
         req_o.tag   <= addr_tag;
         req_o.index <= addr_index;
         req_o.wdata <= wdata_i;
      end
   end

endmodule

/* rtl/cache_way.sv */
`timescale 1ns/1ns

`include "cache_settings.svh"

module cache_way (
   input logic      clk_i,
   input logic      rst_i,
   cache_way_if.way way
);
   import cache_geom_pkg::*;

   localparam int NSETS = 2 ** `CACHE_INDEX_W;

   tag_t             tag_mem  [NSETS];
   word_t            data_mem [NSETS];
   logic [NSETS-1:0] valid_q;

   // lookup address kept for the compare and for later fill or update
   index_t           idx_q;
   tag_t             tag_q;

   // synchronous read of the selected set
   tag_t             rd_tag_q;
   word_t            rd_data_q;
   logic             rd_valid_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q    <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         if (way.lookup_en) begin
            rd_valid_q <= valid_q[way.lookup_index];
         end
         // flush wins, it never overlaps a fill anyway
         if (way.flush_en) begin
            valid_q <= '0;
         end else if (way.fill_en) begin
            valid_q[idx_q] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (way.lookup_en) begin
         idx_q     <= way.lookup_index;
         tag_q     <= way.lookup_tag;
         rd_tag_q  <= tag_mem[way.lookup_index];
         rd_data_q <= data_mem[way.lookup_index];
      end
   end

   always_ff @(posedge clk_i) begin
      if (way.fill_en) begin
         tag_mem[idx_q] <= tag_q;
      end
      // write hit updates the word in place
      if (way.fill_en || way.update_en) begin
         data_mem[idx_q] <= way.wr_data;
      end
   end

   assign way.hit   = rd_valid_q && (rd_tag_q == tag_q);
   assign way.rdata = rd_data_q;

endmodule

/* rtl/cache_controller.sv */
`timescale 1ns/1ns

`include "cache_settings.svh"

module cache_controller (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  cache_geom_pkg::cache_req_t req_i,
   input  logic                       req_valid_i,
   input  logic                       invalidate_i,
   output logic                       ready_o,
   output cache_geom_pkg::word_t      rdata_o,
   output logic                       rvalid_o,
   output logic                       mem_req_o,
   output logic                       mem_we_o,
   output logic [`CACHE_ADDR_W-1:0]   mem_addr_o,
   output cache_geom_pkg::word_t      mem_wdata_o,
   input  cache_geom_pkg::word_t      mem_rdata_i,
   input  logic                       mem_ack_i,
   cache_way_if.ctrl                  ways [`CACHE_NWAYS]
);
   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int NWAYS = `CACHE_NWAYS;

   ctrl_state_e      state_q;
   ctrl_state_e      state;
   mem_op_e          mem_op_q;
   way_t             victim_q;
   logic             resp_q;
   word_t            resp_data_q;
   logic [NWAYS-1:0] hit_vec;
   word_t            way_data [NWAYS];
   word_t            hit_data;
   logic             hit;

   for (genvar i = 0; i < NWAYS; i++) begin : g_way_io
      assign hit_vec[i]         = ways[i].hit;
      assign way_data[i]        = ways[i].rdata;
      assign ways[i].fill_en    = resp_q && (victim_q == way_t'(i));
      assign ways[i].update_en  = (state == st_lookup) && req_i.we && hit_vec[i];
      assign ways[i].wr_data    = resp_q ? resp_data_q : req_i.wdata;
      assign ways[i].flush_en   = (state == st_flush);
   end

   // at most one way hits
   always_comb begin
      hit_data = '0;
      for (int i = 0; i < NWAYS; i++) begin
         if (hit_vec[i]) begin
            hit_data = way_data[i];
         end
      end
   end

   assign hit = |hit_vec;

   // request registered on the last edge, ways answer in this cycle
   always_comb begin
      state = state_q;
      if (state_q == st_idle && req_valid_i) begin
         state = st_lookup;
      end
   end

   assign ready_o  = (state == st_idle) && !resp_q;
   assign rvalid_o = resp_q || ((state == st_lookup) && !req_i.we && hit);
   assign rdata_o  = resp_q ? resp_data_q : hit_data;
   assign mem_we_o = (mem_op_q == mem_write);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q   <= st_idle;
         mem_req_o <= 1'b0;
         mem_op_q  <= mem_read;
         resp_q    <= 1'b0;
         victim_q  <= '0;
      end else begin
         resp_q <= 1'b0;
         case (state)
            st_idle: begin
               if (ready_o && invalidate_i) begin
                  state_q <= st_flush;
               end
            end
            st_lookup: begin
               // stores always go out, a read goes out only on a miss
               if (req_i.we) begin
                  mem_req_o <= 1'b1;
                  mem_op_q  <= mem_write;
                  state_q   <= st_write_through;
               end else if (!hit) begin
                  mem_req_o <= 1'b1;
                  mem_op_q  <= mem_read;
                  state_q   <= st_refill;
               end else begin
                  state_q <= st_idle;
               end
            end
            st_refill: begin
               if (mem_ack_i) begin
                  mem_req_o <= 1'b0;
                  resp_q    <= 1'b1;
                  state_q   <= st_idle;
               end
            end
            st_write_through: begin
               if (mem_ack_i) begin
                  mem_req_o <= 1'b0;
                  state_q   <= st_idle;
               end
            end
            st_flush: state_q <= st_idle;
            default:  state_q <= st_idle;
         endcase
         // next victim once the current fill is written
         if (resp_q) begin
            victim_q <= (victim_q == way_t'(NWAYS - 1)) ? '0 : victim_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == st_lookup) begin
         mem_addr_o  <= {req_i.tag, req_i.index};
         mem_wdata_o <= req_i.wdata;
      end
      if (state == st_refill && mem_ack_i) begin
         resp_data_q <= mem_rdata_i;
      end
   end

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/1ns

`include "cache_settings.svh"

module cache_top (
   input  logic                     clk_i,
   input  logic                     rst_i,
   // processor side
   input  logic                     req_i,
   input  logic [`CACHE_ADDR_W-1:0] addr_i,
   input  logic                     we_i,
   input  cache_geom_pkg::word_t    wdata_i,
   output cache_geom_pkg::word_t    rdata_o,
   output logic                     rvalid_o,
   output logic                     ready_o,
   input  logic                     invalidate_i,
   // memory side
   output logic                     mem_req_o,
   output logic                     mem_we_o,
   output logic [`CACHE_ADDR_W-1:0] mem_addr_o,
   output cache_geom_pkg::word_t    mem_wdata_o,
   input  cache_geom_pkg::word_t    mem_rdata_i,
   input  logic                     mem_ack_i
);
   import cache_geom_pkg::*;

   cache_req_t  fe_req;
   logic        fe_req_valid;

   // one interface per way
   cache_way_if way_if [`CACHE_NWAYS] ();

   cache_front_end u_front_end (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (req_i),
      .addr_i      (addr_i),
      .we_i        (we_i),
      .wdata_i     (wdata_i),
      .ready_i     (ready_o),
      .req_o       (fe_req),
      .req_valid_o (fe_req_valid),
      .ways        (way_if)
   );

   for (genvar i = 0; i < `CACHE_NWAYS; i++) begin : g_way
      cache_way u_way (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .way   (way_if[i])
      );
   end

   cache_controller u_controller (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (fe_req),
      .req_valid_i  (fe_req_valid),
      .invalidate_i (invalidate_i),
      .ready_o      (ready_o),
      .rdata_o      (rdata_o),
      .rvalid_o     (rvalid_o),
      .mem_req_o    (mem_req_o),
      .mem_we_o     (mem_we_o),
      .mem_addr_o   (mem_addr_o),
      .mem_wdata_o  (mem_wdata_o),
      .mem_rdata_i  (mem_rdata_i),
      .mem_ack_i    (mem_ack_i),
      .ways         (way_if)
   );

endmodule

/* verification/cache_assert.sv */
`timescale 1ns/1ns

`include "cache_settings.svh"

module cache_assert (
   input logic                     clk_i,
   input logic                     rst_i,
   input logic                     ready_i,
   input logic                     rvalid_i,
   input logic                     mem_req_i,
   input logic                     mem_we_i,
   input logic [`CACHE_ADDR_W-1:0] mem_addr_i,
   input cache_geom_pkg::word_t    mem_wdata_i,
   input logic                     mem_ack_i
);

   // read by the testbench at the end of the run
   int fail_count;

   // idle ports in the cycle after a reset edge
   a_reset_state: assert property (@(posedge clk_i)
      rst_i |=> ready_i && !mem_req_i && !rvalid_i)
      else begin
         fail_count++;
         $error("outputs not in reset state after reset");
      end

   // back-end request held with its address and data until acked
   a_mem_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i)
         && $stable(mem_we_i) && $stable(mem_wdata_i))
      else begin
         fail_count++;
         $error("mem_req_o or its address and data changed before mem_ack_i");
      end

   a_rvalid_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      rvalid_i |=> !rvalid_i)
      else begin
         fail_count++;
         $error("rvalid_o high for more than one cycle");
      end

   a_busy_on_mem_req: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_req_i |-> !ready_i)
      else begin
         fail_count++;
         $error("ready_o high while mem_req_o is pending");
      end

endmodule

/* verification/cache_tb.sv */
`timescale 1ns/1ns

`include "cache_settings.svh"

module cache_tb;
   import cache_geom_pkg::*;

   localparam int TIMEOUT = 40;

   logic                     clk;
   logic                     rst;
   logic                     req;
   logic [`CACHE_ADDR_W-1:0] addr;
   logic                     we;
   word_t                    wdata;
   word_t                    rdata;
   logic                     rvalid;
   logic                     ready;
   logic                     invalidate;
   logic                     mem_req;
   logic                     mem_we;
   logic [`CACHE_ADDR_W-1:0] mem_addr;
   word_t                    mem_wdata;
   word_t                    mem_rdata;
   logic                     mem_ack;

   logic [31:0]              lfsr;
   // ref_mem mirrors the stores, mem_model is the back end's own copy
   word_t                    ref_mem [int];
   word_t                    mem_model [int];
   int                       mem_reads;
   int                       mem_writes;
   logic [`CACHE_ADDR_W-1:0] last_wr_addr;
   word_t                    last_wr_data;
   int                       mismatches;
   int                       timeouts;

   cache_top dut (
      .clk_i        (clk),
      .rst_i        (rst),
      .req_i        (req),
      .addr_i       (addr),
      .we_i         (we),
      .wdata_i      (wdata),
      .rdata_o      (rdata),
      .rvalid_o     (rvalid),
      .ready_o      (ready),
      .invalidate_i (invalidate),
      .mem_req_o    (mem_req),
      .mem_we_o     (mem_we),
      .mem_addr_o   (mem_addr),
      .mem_wdata_o  (mem_wdata),
      .mem_rdata_i  (mem_rdata),
      .mem_ack_i    (mem_ack)
   );

   bind cache_top cache_assert u_assert (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ready_i     (ready_o),
      .rvalid_i    (rvalid_o),
      .mem_req_i   (mem_req_o),
      .mem_we_i    (mem_we_o),
      .mem_addr_i  (mem_addr_o),
      .mem_wdata_i (mem_wdata_o),
      .mem_ack_i   (mem_ack_i)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   // unwritten words, built from every address bit
   function automatic word_t fill_word(input logic [`CACHE_ADDR_W-1:0] a);
      return word_t'({a, ~a, a});
   endfunction

   function automatic word_t expected_word(input logic [`CACHE_ADDR_W-1:0] a);
      return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : fill_word(a);
   endfunction

   function automatic logic [`CACHE_ADDR_W-1:0] set_addr(input int tag, input int index);
      return {tag_t'(tag), index_t'(index)};
   endfunction

   task automatic report_mismatch(input string msg);
      mismatches++;
      $display("Mismatch at %0t ns: %s", $time, msg);
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!ready) begin
         timeouts++;
         $display("Error at %0t ns: cache never became ready again", $time);
      end
   endtask

   // exp_hit is 1 for a hit, 0 for a miss, -1 when either is fine
   task automatic read_word(input logic [`CACHE_ADDR_W-1:0] a, input int exp_hit);
      int    n;
      int    reads_before;
      word_t exp;
      exp = expected_word(a);
      wait_ready();
      reads_before = mem_reads;
      req  = 1'b1;
      addr = a;
      we   = 1'b0;
      @(negedge clk);
      req = 1'b0;
      n   = 1;
      while (!rvalid && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!rvalid) begin
         timeouts++;
         $display("Error at %0t ns: no read data came back for address %h", $time, a);
      end else begin
         assert (rdata == exp)
            else report_mismatch($sformatf("read %h gave %h, expected %h", a, rdata, exp));
         if (exp_hit == 0) begin
            assert (mem_reads == reads_before + 1)
               else report_mismatch($sformatf("read %h did not refill once", a));
         end
         @(negedge clk);
         if (exp_hit == 1) begin
            assert (n == 1 && mem_reads == reads_before && !mem_req && ready)
               else report_mismatch($sformatf("read %h was not a one-cycle hit", a));
         end
      end
   endtask

   task automatic write_word(input logic [`CACHE_ADDR_W-1:0] a, input word_t d);
      int n;
      int writes_before;
      wait_ready();
      writes_before    = mem_writes;
      ref_mem[int'(a)] = d;
      req   = 1'b1;
      addr  = a;
      we    = 1'b1;
      wdata = d;
      @(negedge clk);
      req = 1'b0;
      we  = 1'b0;
      n   = 0;
      while (!ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!ready) begin
         timeouts++;
         $display("Error at %0t ns: write to %h never completed", $time, a);
      end else begin
         assert (mem_writes == writes_before + 1 && last_wr_addr == a && last_wr_data == d)
            else report_mismatch($sformatf("write %h of %h not passed to memory", a, d));
      end
   endtask

   task automatic invalidate_all();
      wait_ready();
      invalidate = 1'b1;
      @(negedge clk);
      invalidate = 1'b0;
      assert (!ready) else report_mismatch("ready_o stayed high during invalidate");
      @(negedge clk);
      assert (ready) else report_mismatch("invalidate held ready_o low too long");
   endtask

   // back end, acks after 0 to 3 cycles
   initial begin : memory
      int delay;
      bit busy;
      int key;
      mem_ack    = 1'b0;
      mem_rdata  = '0;
      mem_reads  = 0;
      mem_writes = 0;
      busy       = 1'b0;
      delay      = 0;
      forever begin
         @(negedge clk);
         key = int'(mem_addr);
         if (mem_ack) begin
            mem_ack = 1'b0;
         end else if (mem_req) begin
            if (!busy) begin
               busy  = 1'b1;
               delay = int'(rand_bits(2));
            end
            if (delay == 0) begin
               busy    = 1'b0;
               mem_ack = 1'b1;
               if (mem_we) begin
                  mem_model[key] = mem_wdata;
                  last_wr_addr   = mem_addr;
                  last_wr_data   = mem_wdata;
                  mem_writes++;
               end else begin
                  mem_rdata = mem_model.exists(key) ? mem_model[key] : fill_word(mem_addr);
                  mem_reads++;
               end
            end else begin
               delay--;
            end
         end
      end
   end

   initial begin : stimulus
      logic [`CACHE_ADDR_W-1:0] a;
      int                       op;
      lfsr       = 32'h1950_7e40;
      rst        = 1'b1;
      req        = 1'b0;
      addr       = '0;
      we         = 1'b0;
      wdata      = '0;
      invalidate = 1'b0;
      repeat (10) @(negedge clk);
      rst = 1'b0;

      read_word(12'h0a1, 0);
      read_word(12'h0a1, 1);
      // write hit, then write miss that must not allocate
      write_word(12'h0a1, 32'hcafe_0a11);
      read_word(12'h0a1, 1);
      write_word(12'h3c2, 32'h0bad_f00d);
      read_word(12'h3c2, 0);
      // one tag more than ways in set 6
      for (int k = 0; k <= `CACHE_NWAYS; k++) begin
         read_word(set_addr('h50 + k, 6), 0);
      end
      read_word(set_addr('h50, 6), 0);
      read_word(set_addr('h50 + `CACHE_NWAYS, 6), 1);
      read_word(12'h0a1, 1);
      invalidate_all();
      read_word(12'h0a1, 0);

      // mixed traffic over a few tags per set
      repeat (150) begin
         a  = set_addr('h100 + int'(rand_bits(2)), int'(rand_bits(3)));
         op = int'(rand_bits(4));
         if (op == 0) begin
            invalidate_all();
         end else if (op < 8) begin
            write_word(a, word_t'(rand_bits(32)));
         end else begin
            read_word(a, -1);
         end
      end
      wait_ready();

      $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               mismatches, timeouts, dut.u_assert.fail_count);
      if (mismatches == 0 && timeouts == 0 && dut.u_assert.fail_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+rtl
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/cache_way_if.sv
rtl/cache_front_end.sv
rtl/cache_way.sv
rtl/cache_controller.sv
rtl/cache_top.sv
verification/cache_assert.sv
verification/cache_tb.sv

/* Makefile */
# Verilator build and run of the cache testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module cache_tb -o cache_sim
	./obj_dir/cache_sim +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
